//--- common/fb_params.svh
`ifndef FB_PARAMS_SVH
`define FB_PARAMS_SVH

// horizontal timing, in pixel clocks
`define H_ACTIVE 640
`define H_FP 16
`define H_SYNC 96
`define H_TOTAL 800

// vertical timing, in lines
`define V_ACTIVE 480
`define V_FP 10
`define V_SYNC 2
`define V_TOTAL 525

`define WORDS_PER_ROW 40 // 16-pixel words per row

// external SRAM pins
`define SRAM_ADDR_W 18
`define SRAM_DATA_W 16

`endif

//--- common/video_pkg.sv
`default_nettype none

package video_pkg;

    // raw counter values from the timing generator
    typedef logic [10:0] hcount_t; // 0 .. 799
    typedef logic [9:0]  vcount_t; // 0 .. 524

    // visible screen coordinates
    // the widths cover the active area plus some headroom, so a tracker
    // can hand in out-of-range values that the controller filters out
    typedef logic [9:0]  coord_x_t;
    typedef logic [8:0]  coord_y_t;

endpackage

`default_nettype wire

//--- common/mem_pkg.sv
`default_nettype none

`include "fb_params.svh"

package mem_pkg;

    // word address into the framebuffer, row * 40 + word
    typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;

    // one word holds 16 pixels, leftmost pixel in the msb
    typedef logic [`SRAM_DATA_W-1:0] sram_word_t;

endpackage

`default_nettype wire

//--- common/sram_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface sram_bus_if;
    import mem_pkg::*;

    logic       req_valid;
    logic       req_write;  // 1 = write, 0 = read
    sram_addr_t req_addr;
    sram_word_t req_wdata;
    logic       req_ready;  // low for one cycle after a write

    // read return, two cycles after acceptance, in order
    logic       rd_valid;
    sram_word_t rd_data;

    modport client (
        output req_valid, req_write, req_addr, req_wdata,
        input  req_ready, rd_valid, rd_data
    );

    modport server (
        input  req_valid, req_write, req_addr, req_wdata,
        output req_ready, rd_valid, rd_data
    );

endinterface

`default_nettype wire

//--- src/vga_timing.sv
`timescale 1ns/1ns
`default_nettype none

`include "fb_params.svh"

module vga_timing (
    input  logic              clk,
    input  logic              rst_n,
    output video_pkg::hcount_t hcount,
    output video_pkg::vcount_t vcount,
    output logic              hsync,
    output logic              vsync,
    output logic              blank
);

    logic h_last;
    logic v_last;
    logic h_sync_win;
    logic v_sync_win;
    logic active;

    assign h_last = (hcount == `H_TOTAL - 1);
    assign v_last = (vcount == `V_TOTAL - 1);

    // sync windows sit right after the front porch
    assign h_sync_win = (hcount >= `H_ACTIVE + `H_FP) &&
                        (hcount <  `H_ACTIVE + `H_FP + `H_SYNC);
    assign v_sync_win = (vcount >= `V_ACTIVE + `V_FP) &&
                        (vcount <  `V_ACTIVE + `V_FP + `V_SYNC);
    assign active     = (hcount < `H_ACTIVE) && (vcount < `V_ACTIVE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
        end else if (h_last) begin
            hcount <= '0;
            vcount <= v_last ? '0 : vcount + 1'b1; // wrap at end of frame
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // outputs lag the counters by one cycle, same as the pixel path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            blank <= 1'b0;
        end else begin
            hsync <= ~h_sync_win; // active low
            vsync <= ~v_sync_win; // active low
            blank <= ~active;
        end
    end

endmodule

`default_nettype wire

//--- framebuffer/fb_controller.sv
`timescale 1ns/1ns
`default_nettype none

`include "fb_params.svh"

module fb_controller (
    input  logic                clk,
    input  logic                rst_n,
    input  video_pkg::hcount_t  hcount,
    input  video_pkg::vcount_t  vcount,
    input  logic                spot_valid,
    output logic                spot_ready,
    input  video_pkg::coord_x_t spot_x,
    input  video_pkg::coord_y_t spot_y,
    sram_bus_if.client          mem,
    output logic                pixel
);
    import video_pkg::*;
    import mem_pkg::*;

    logic                 pending;  // one spot waiting for vertical blank
    coord_x_t             pend_x;
    coord_y_t             pend_y;
    logic                 accept;
    logic                 in_range;
    logic                 issue;
    logic                 fetch_start;
    logic                 write_start;
    coord_y_t             next_row;
    sram_addr_t           row_base;
    sram_addr_t           spot_addr;
    sram_word_t           spot_word;
    logic [5:0]           rd_cnt;   // reads accepted this fetch
    logic [5:0]           ret_cnt;  // words landed in the line buffer
    logic [`H_ACTIVE-1:0] line_buf;

    assign spot_ready = ~pending;
    assign accept     = spot_valid & ~pending;
    assign in_range   = (spot_x < `H_ACTIVE) && (spot_y < `V_ACTIVE);
    assign issue      = mem.req_valid & mem.req_ready;

    assign fetch_start = (hcount == `H_ACTIVE); // first cycle of hblank
    assign write_start = pending && (hcount == 0) && (vcount == `V_ACTIVE);

    // row shown on the next line, row 0 through vertical blank
    assign next_row  = (vcount < `V_ACTIVE - 1) ? coord_y_t'(vcount + 1'b1) : '0;
    assign row_base  = sram_addr_t'(next_row * `WORDS_PER_ROW);
    assign spot_addr = sram_addr_t'(pend_y * `WORDS_PER_ROW) + sram_addr_t'(pend_x[9:4]);
    assign spot_word = sram_word_t'(16'h8000) >> pend_x[3:0]; // one-hot, msb is leftmost

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (accept && in_range) begin
            pending <= 1'b1; // out-of-range spots are taken and dropped
        end else if (issue && mem.req_write) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pend_x <= spot_x;
            pend_y <= spot_y;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem.req_valid <= 1'b0;
            rd_cnt        <= '0;
        end else if (fetch_start) begin
            mem.req_valid <= 1'b1;
            rd_cnt        <= '0;
        end else if (write_start) begin
            mem.req_valid <= 1'b1;
        end else if (issue) begin
            if (mem.req_write) begin
                mem.req_valid <= 1'b0;
            end else begin
                rd_cnt <= rd_cnt + 1'b1;
                if (rd_cnt == 6'(`WORDS_PER_ROW - 1))
                    mem.req_valid <= 1'b0; // whole row requested
            end
        end
    end

    // request fields stay put until the bus takes them
    always_ff @(posedge clk) begin
        if (fetch_start) begin
            mem.req_write <= 1'b0;
            mem.req_addr  <= row_base;
        end else if (write_start) begin
            mem.req_write <= 1'b1;
            mem.req_addr  <= spot_addr;
            mem.req_wdata <= spot_word;
        end else if (issue && !mem.req_write) begin
            mem.req_addr <= mem.req_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            ret_cnt <= '0;
        else if (fetch_start)
            ret_cnt <= '0;
        else if (mem.rd_valid)
            ret_cnt <= ret_cnt + 1'b1;
    end

    // returns come back in order, so the count is the word index
    always_ff @(posedge clk) begin
        if (mem.rd_valid)
            line_buf[{ret_cnt, 4'b0000} +: `SRAM_DATA_W] <= mem.rd_data;
    end

    // column c lives in bit 15 - c%16 of its word, hence the inverted low bits
    always_ff @(posedge clk) begin
        if (!rst_n)
            pixel <= 1'b0;
        else if ((hcount < `H_ACTIVE) && (vcount < `V_ACTIVE))
            pixel <= line_buf[{hcount[9:4], ~hcount[3:0]}];
        else
            pixel <= 1'b0;
    end

endmodule

`default_nettype wire

//--- src/sram_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module sram_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    sram_bus_if.server          bus,
    output mem_pkg::sram_addr_t sram_addr,
    input  mem_pkg::sram_word_t sram_dq_in,
    output mem_pkg::sram_word_t sram_dq_out,
    output logic                sram_dq_oe,
    output logic                sram_ce_n,
    output logic                sram_oe_n,
    output logic                sram_we_n
);

    logic accepted;
    logic turnaround; // bus released by the write driver

    assign accepted      = bus.req_valid & bus.req_ready;
    assign bus.req_ready = ~turnaround;

    // strobes, one pin cycle per accepted request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sram_ce_n  <= 1'b1;
            sram_oe_n  <= 1'b1;
            sram_we_n  <= 1'b1;
            sram_dq_oe <= 1'b0;
            turnaround <= 1'b0;
        end else begin
            sram_ce_n  <= ~accepted;
            sram_oe_n  <= ~(accepted & ~bus.req_write);
            sram_we_n  <= ~(accepted & bus.req_write);
            sram_dq_oe <= accepted & bus.req_write;
            turnaround <= accepted & bus.req_write;
        end
    end

    always_ff @(posedge clk) begin
        if (accepted) begin
            sram_addr   <= bus.req_addr;
            sram_dq_out <= bus.req_wdata;
        end
    end

    // sample the data at the end of the read pin cycle
    always_ff @(posedge clk) begin
        if (!rst_n)
            bus.rd_valid <= 1'b0;
        else
            bus.rd_valid <= ~sram_oe_n;
    end

    always_ff @(posedge clk) begin
        bus.rd_data <= sram_dq_in;
    end

endmodule

`default_nettype wire

//--- src/spot_display_top.sv
`timescale 1ns/1ns
`default_nettype none

module spot_display_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                spot_valid,
    output logic                spot_ready,
    input  video_pkg::coord_x_t spot_x,
    input  video_pkg::coord_y_t spot_y,
    output logic                hsync,
    output logic                vsync,
    output logic                blank,
    output logic                pixel,
    output mem_pkg::sram_addr_t sram_addr,
    input  mem_pkg::sram_word_t sram_dq_in,
    output mem_pkg::sram_word_t sram_dq_out,
    output logic                sram_dq_oe,
    output logic                sram_ce_n,
    output logic                sram_oe_n,
    output logic                sram_we_n
);
    import video_pkg::*;

    hcount_t hcount;
    vcount_t vcount;

    sram_bus_if sram_bus_i ();

    vga_timing vga_timing_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .hcount (hcount),
        .vcount (vcount),
        .hsync  (hsync),
        .vsync  (vsync),
        .blank  (blank)
    );

    fb_controller fb_controller_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .hcount     (hcount),
        .vcount     (vcount),
        .spot_valid (spot_valid),
        .spot_ready (spot_ready),
        .spot_x     (spot_x),
        .spot_y     (spot_y),
        .mem        (sram_bus_i.client),
        .pixel      (pixel)
    );

    sram_ctrl sram_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (sram_bus_i.server),
        .sram_addr   (sram_addr),
        .sram_dq_in  (sram_dq_in),
        .sram_dq_out (sram_dq_out),
        .sram_dq_oe  (sram_dq_oe),
        .sram_ce_n   (sram_ce_n),
        .sram_oe_n   (sram_oe_n),
        .sram_we_n   (sram_we_n)
    );

endmodule

`default_nettype wire

//--- testbench/sram_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "fb_params.svh"

module sram_model (
    input  mem_pkg::sram_addr_t sram_addr,
    output mem_pkg::sram_word_t sram_dq_in,
    input  mem_pkg::sram_word_t sram_dq_out,
    input  logic                sram_dq_oe,
    input  logic                sram_ce_n,
    input  logic                sram_oe_n,
    input  logic                sram_we_n
);
    import mem_pkg::*;

    localparam int DEPTH = 1 << `SRAM_ADDR_W;

    sram_word_t mem [0:DEPTH-1];

    initial begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = '0; // screen starts dark
    end

    // asynchronous read, the bus floats low when not selected
    assign sram_dq_in = (!sram_ce_n && !sram_oe_n) ? mem[sram_addr] : '0;

    // level sensitive write while chip and write strobe are both low
    always @(sram_addr or sram_dq_out or sram_dq_oe or sram_ce_n or sram_we_n) begin
        if (!sram_ce_n && !sram_we_n && sram_dq_oe)
            mem[sram_addr] = sram_dq_out;
    end

    // backdoor read for end-of-run checks
    function automatic sram_word_t peek(input sram_addr_t addr);
        return mem[addr];
    endfunction

endmodule

`default_nettype wire

//--- testbench/tb_spot_display.sv
`timescale 1ns/1ns
`default_nettype none

`include "fb_params.svh"

module tb_spot_display;
    import video_pkg::*;
    import mem_pkg::*;

    localparam int NUM_FRAMES = 14;
    localparam int FRAME_CYC  = `H_TOTAL * `V_TOTAL;
    localparam int TIMEOUT_NS = (NUM_FRAMES + 1) * FRAME_CYC * 8;
    localparam int ROW_WORDS  = `V_ACTIVE * `WORDS_PER_ROW;

    logic clk = 1'b0;
    logic rst_n, spot_valid, spot_ready, hsync, vsync, blank, pixel;
    coord_x_t spot_x;
    coord_y_t spot_y;
    sram_addr_t sram_addr;
    sram_word_t sram_dq_in, sram_dq_out;
    logic sram_dq_oe, sram_ce_n, sram_oe_n, sram_we_n;

    logic [15:0] ref_mem [0:ROW_WORDS-1]; // words as seen by the shown frame
    int qx[$], qy[$];                     // accepted spots not yet in vblank
    logic [31:0] rnd_state = 32'h4617f056;
    int pix_errs = 0, timing_errs = 0, other_errs = 0;
    int cyc = 0, row = -1, col = 0, vs_rises = 0;
    logic synced = 1'b0, vblank = 1'b1;
    logic p_blank = 1'b0, p_hsync = 1'b1, p_vsync = 1'b1;
    int t_hfall = -1, t_vfall = -1, t_brise = -1;

    always #4 clk = ~clk;

    spot_display_top spot_display_top_i (.*);

    sram_model sram_model_i (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic expected_pixel(input int c, input int r);
        logic [15:0] w;
        w = ref_mem[r * `WORDS_PER_ROW + c / 16];
        return w[15 - c % 16]; // leftmost pixel in the msb
    endfunction

    // in-range spots from completed handshakes
    always @(posedge clk) begin
        if (rst_n && spot_valid && spot_ready && spot_x < `H_ACTIVE && spot_y < `V_ACTIVE) begin
            qx.push_back(int'(spot_x));
            qy.push_back(int'(spot_y));
        end
    end

    // output stream tracker and compare at mid-cycle
    always @(negedge clk) begin
        int sx;
        int sy;
        cyc++;
        if (rst_n) begin
            if (!hsync && p_hsync) begin
                if (t_hfall >= 0 && cyc - t_hfall != `H_TOTAL) begin
                    $display("ERROR %0t: line length %0d cycles", $time, cyc - t_hfall);
                    timing_errs++;
                end
                t_hfall = cyc;
            end
            if (hsync && !p_hsync && t_hfall >= 0 && cyc - t_hfall != `H_SYNC) begin
                $display("ERROR %0t: hsync pulse %0d cycles", $time, cyc - t_hfall);
                timing_errs++;
            end
            if (!vsync && p_vsync) begin
                if (t_vfall >= 0 && cyc - t_vfall != FRAME_CYC) begin
                    $display("ERROR %0t: frame length %0d cycles", $time, cyc - t_vfall);
                    timing_errs++;
                end
                t_vfall = cyc;
            end
            if (vsync && !p_vsync) begin
                if (t_vfall >= 0 && cyc - t_vfall != `V_SYNC * `H_TOTAL) begin
                    $display("ERROR %0t: vsync pulse %0d cycles", $time, cyc - t_vfall);
                    timing_errs++;
                end
                synced = 1'b1;
                row = -1;
                vblank = 1'b1;
                vs_rises++;
            end
            if (blank && !p_blank) begin
                t_brise = cyc;
                if (synced && row == `V_ACTIVE - 1) begin
                    vblank = 1'b1; // DUT writes its pending spot now
                    while (qx.size() > 0) begin
                        sx = qx.pop_front();
                        sy = qy.pop_front();
                        ref_mem[sy * `WORDS_PER_ROW + sx / 16] = 16'h8000 >> (sx % 16);
                    end
                end
            end
            if (!blank && p_blank) begin
                if (t_brise >= 0 && cyc - t_brise != `H_TOTAL - `H_ACTIVE &&
                    cyc - t_brise != (`V_TOTAL - `V_ACTIVE) * `H_TOTAL + `H_TOTAL - `H_ACTIVE) begin
                    $display("ERROR %0t: blank interval %0d cycles", $time, cyc - t_brise);
                    timing_errs++;
                end
                row++;
                col = 0;
                vblank = 1'b0;
            end
            if (blank && pixel === 1'b1) begin
                $display("ERROR %0t: pixel high during blank", $time);
                pix_errs++;
            end
            if (!blank && synced) begin
                if (col >= `H_ACTIVE || row >= `V_ACTIVE) begin
                    $display("ERROR %0t: active pixel outside screen (%0d,%0d)", $time, col, row);
                    timing_errs++;
                end else if (pixel !== expected_pixel(col, row)) begin
                    $display("ERROR %0t: pixel (%0d,%0d) is %b, expected %b",
                             $time, col, row, pixel, expected_pixel(col, row));
                    pix_errs++;
                end
                col++;
            end
            // each pin cycle is idle, one read or one write
            if (sram_ce_n ? (!sram_oe_n || !sram_we_n || sram_dq_oe)
                          : (sram_oe_n == sram_we_n || sram_dq_oe == sram_we_n)) begin
                $display("ERROR %0t: sram strobes ce_n %b oe_n %b we_n %b dq_oe %b",
                         $time, sram_ce_n, sram_oe_n, sram_we_n, sram_dq_oe);
                other_errs++;
            end
        end
        p_blank = blank;
        p_hsync = hsync;
        p_vsync = vsync;
    end

    task automatic send_spot(input int x, input int y, output int waited);
        waited = 0;
        spot_valid <= 1'b1;
        spot_x     <= coord_x_t'(x);
        spot_y     <= coord_y_t'(y);
        @(posedge clk);
        while (!spot_ready) begin
            waited++;
            @(posedge clk);
        end
        spot_valid <= 1'b0;
    endtask

    task automatic pick_spot(output int x, output int y);
        rnd_state = lcg_next(rnd_state);
        x = rnd_state[31:16] % `H_ACTIVE;
        rnd_state = lcg_next(rnd_state);
        y = rnd_state[31:16] % `V_ACTIVE;
    endtask

    task automatic wait_row(input int r);
        do @(posedge clk); while (!(synced && !vblank && row == r));
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = vs_rises + n;
        while (vs_rises < target)
            @(posedge clk);
    endtask

    initial begin
        int ax, ay, bx, by, x, y, w;
        for (int i = 0; i < ROW_WORDS; i++)
            ref_mem[i] = '0;
        rst_n <= 1'b0;
        spot_valid <= 1'b0;
        spot_x <= '0;
        spot_y <= '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        wait_row(100);             // first full frame is checked dark meanwhile
        pick_spot(ax, ay);
        send_spot(ax, ay, w);
        wait_frames(2);
        wait_row(100);
        pick_spot(bx, by);
        if (by == ay && bx / 16 == ax / 16)
            by = (ay + 1) % `V_ACTIVE;
        send_spot(bx, by, w);
        wait_frames(2);
        wait_row(100);
        send_spot((ax & ~15) | ((ax % 16) ^ 5), ay, w); // same word as spot a so it clears a
        wait_frames(2);

        wait_row(100);
        pick_spot(x, y);
        send_spot(x, y, w);
        if (w != 0) begin
            $display("ERROR %0t: first spot waited %0d cycles", $time, w);
            other_errs++;
        end
        pick_spot(x, y);
        send_spot(x, y, w);        // held valid behind the pending spot
        if (w == 0 || !vblank) begin
            $display("ERROR %0t: held spot taken before vertical blank", $time);
            other_errs++;
        end
        wait_frames(3);

        wait_row(100);
        send_spot(700, 10, w);
        send_spot(5, 490, w);
        @(posedge clk);
        if (!spot_ready) begin
            $display("ERROR %0t: out of range spot left spot_ready low", $time);
            other_errs++;
        end
        wait_frames(2);

        for (int i = 0; i < ROW_WORDS; i++) begin
            if (sram_model_i.peek(sram_addr_t'(i)) !== ref_mem[i]) begin
                $display("ERROR %0t: sram word %0d is %h, expected %h",
                         $time, i, sram_model_i.peek(sram_addr_t'(i)), ref_mem[i]);
                other_errs++;
            end
        end
        $display("errors: pixel %0d, timing %0d, other %0d", pix_errs, timing_errs, other_errs);
        if (pix_errs + timing_errs + other_errs == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // watchdog sized for the frames above plus one spare
    initial begin
        #(TIMEOUT_NS);
        $display("Simulation timed out before all tests finished");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+common
common/video_pkg.sv
common/mem_pkg.sv
common/sram_bus_if.sv
src/vga_timing.sv
framebuffer/fb_controller.sv
src/sram_ctrl.sv
src/spot_display_top.sv
testbench/sram_model.sv
testbench/tb_spot_display.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_spot_display
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
